// File: periph_soc.f
source/soc_pkg.sv
source/apb_if.sv
source/apb_bridge.sv
source/clint_timer.sv
source/irq_ctrl.sv
source/periph_soc.sv
verif/periph_soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from sim.log.
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module periph_soc_tb -f periph_soc.f \
    && ./obj_dir/Vperiph_soc_tb > sim.log 2>&1
grep -q "^TEST OK$" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: verif/periph_soc_tb.sv
`timescale 1ns/1ps

module periph_soc_tb import soc_pkg::*; ();
    localparam int CLK_PERIOD     = 10;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int RESP_LATENCY   = 3;

    localparam logic [ADDR_W-1:0] MTIME_ADDR    = TIMER_BASE | {8'h00, OFF_MTIME};
    localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = TIMER_BASE | {8'h00, OFF_MTIMECMP};
    localparam logic [ADDR_W-1:0] CTRL_ADDR     = TIMER_BASE | {8'h00, OFF_CTRL};
    localparam logic [ADDR_W-1:0] PENDING_ADDR  = IRQC_BASE | {8'h00, OFF_PENDING};
    localparam logic [ADDR_W-1:0] ENABLE_ADDR   = IRQC_BASE | {8'h00, OFF_ENABLE};
    localparam logic [ADDR_W-1:0] CLAIM_ADDR    = IRQC_BASE | {8'h00, OFF_CLAIM};

    logic              clk;
    logic              reset_i;
    logic              req_valid_i;
    logic              req_write_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_wdata_i;
    logic              resp_valid_o;
    logic [DATA_W-1:0] resp_rdata_o;
    logic              resp_err_o;
    logic [3:0]        ext_src_i;
    logic              ext_irq_o;
    logic              timer_irq_o;

    int                 errors;
    int                 seed;
    logic [DATA_W-1:0]  exp_data_q[$];
    logic [DATA_W-1:0]  exp_mask_q[$];
    logic               exp_err_q[$];
    logic [DATA_W-1:0]  cmp_data;
    logic [DATA_W-1:0]  cmp_mask;
    logic               cmp_err;
    logic [IRQ_NUM-1:0] model_pending;   // Shadow of the controller state.
    logic [IRQ_NUM-1:0] model_enable;

    periph_soc u_periph_soc (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Lowest pending and enabled source, reported as id plus one.
    function automatic logic [DATA_W-1:0] expected_claim(input logic [IRQ_NUM-1:0] pending,
                                                         input logic [IRQ_NUM-1:0] enable);
        logic [IRQ_NUM-1:0] active;
        logic [DATA_W-1:0]  id;
        active = pending & enable;
        id     = '0;
        for (int i = 0; i < IRQ_NUM; i++) begin
            if (active[i] && id == 0)
                id = i + 1;
        end
        return id;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Starts on a falling edge and returns one falling edge after the response.
    task automatic issue_request(input logic write, input logic [ADDR_W-1:0] addr,
                                 input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp_data,
                                 input logic [DATA_W-1:0] exp_mask, input logic exp_err,
                                 output logic [DATA_W-1:0] rdata);
        int   cycles;
        logic seen;
        exp_data_q.push_back(exp_data);
        exp_mask_q.push_back(exp_mask);
        exp_err_q.push_back(exp_err);
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        cycles      = 0;
        seen        = 1'b0;
        rdata       = '0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            req_valid_i = 1'b0;   // One-cycle strobe.
            if (resp_valid_o) begin
                seen  = 1'b1;
                rdata = resp_rdata_o;
            end
        end
        if (!seen) begin
            errors++;
            $display("No response from address %h within %0d cycles", addr, TIMEOUT_CYCLES);
            exp_data_q.delete();
            exp_mask_q.delete();
            exp_err_q.delete();
        end else begin
            assert (cycles == RESP_LATENCY) else begin
                errors++;
                $display("error %0t: response from %h after %0d cycles", $time, addr, cycles);
            end
            @(negedge clk);   // Bridge leaves RESP and is idle again.
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic exp_err);
        logic [DATA_W-1:0] unused_rdata;
        issue_request(1'b1, addr, data, '0, '0, exp_err, unused_rdata);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_data,
                            input logic [DATA_W-1:0] exp_mask, input logic exp_err,
                            output logic [DATA_W-1:0] rdata);
        issue_request(1'b0, addr, '0, exp_data, exp_mask, exp_err, rdata);
    endtask

    // Every response is held against the oldest expectation.
    always @(negedge clk) begin
        if (resp_valid_o) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("A response arrived at %0t with no request outstanding", $time);
            end else begin
                cmp_data = exp_data_q.pop_front();
                cmp_mask = exp_mask_q.pop_front();
                cmp_err  = exp_err_q.pop_front();
                assert ((resp_rdata_o & cmp_mask) == (cmp_data & cmp_mask)) else begin
                    errors++;
                    $display("error %0t: read data %h, expected %h", $time, resp_rdata_o, cmp_data);
                end
                assert (resp_err_o == cmp_err) else begin
                    errors++;
                    $display("error %0t: resp_err_o is %b, expected %b", $time, resp_err_o, cmp_err);
                end
            end
        end
    end

    initial begin
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] first;
        logic [DATA_W-1:0] claim;
        int                cycles;
        seed          = 32'h3d54_449f;
        errors        = 0;
        reset_i       = 1'b1;
        req_valid_i   = 1'b0;
        req_write_i   = 1'b0;
        req_addr_i    = '0;
        req_wdata_i   = '0;
        ext_src_i     = '0;
        model_pending = '0;
        model_enable  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        check_bit(timer_irq_o, 1'b0, "timer_irq_o after reset");
        check_bit(ext_irq_o, 1'b0, "ext_irq_o after reset");
        read_reg(CTRL_ADDR, '0, '1, 1'b0, rdata);

        repeat (4) begin
            value = $random(seed);
            write_reg(MTIMECMP_ADDR, value, 1'b0);
            read_reg(MTIMECMP_ADDR, value, '1, 1'b0, rdata);
            write_reg(ENABLE_ADDR, value, 1'b0);
            model_enable = value[IRQ_NUM-1:0];
            read_reg(ENABLE_ADDR, DATA_W'(model_enable), '1, 1'b0, rdata);
            write_reg(MTIME_ADDR, ~value, 1'b0);   // Timer still disabled.
            read_reg(MTIME_ADDR, ~value, '1, 1'b0, rdata);
        end

        write_reg(16'h0204, '1, 1'b1);
        read_reg(16'h0200, '0, '1, 1'b1, rdata);
        write_reg(TIMER_BASE | 16'h000C, '1, 1'b1);
        read_reg(IRQC_BASE | 16'h000C, '0, '1, 1'b1, rdata);
        write_reg(PENDING_ADDR, '1, 1'b1);
        read_reg(PENDING_ADDR, DATA_W'(model_pending), '1, 1'b0, rdata);
        read_reg(MTIMECMP_ADDR, value, '1, 1'b0, rdata);
        read_reg(ENABLE_ADDR, DATA_W'(model_enable), '1, 1'b0, rdata);

        write_reg(MTIME_ADDR, '0, 1'b0);
        write_reg(MTIMECMP_ADDR, 32'hFFFF_FFFF, 1'b0);
        write_reg(CTRL_ADDR, 32'hFFFF_FFF1, 1'b0);   // Reserved bits set too.
        read_reg(CTRL_ADDR, 32'h1, '1, 1'b0, rdata);
        repeat (50) begin
            @(negedge clk);
            check_bit(timer_irq_o, 1'b0, "timer_irq_o before compare match");
        end
        write_reg(MTIMECMP_ADDR, '0, 1'b0);
        cycles = 0;
        while (!timer_irq_o && cycles < 5) begin
            @(negedge clk);
            cycles++;
        end
        check_bit(timer_irq_o, 1'b1, "timer_irq_o after compare match");
        read_reg(MTIME_ADDR, '0, '0, 1'b0, first);
        read_reg(MTIME_ADDR, '0, '0, 1'b0, rdata);
        assert (rdata > first) else begin
            errors++;
            $display("error %0t: mtime went from %h to %h", $time, first, rdata);
        end
        write_reg(CTRL_ADDR, '0, 1'b0);
        model_pending[0] = 1'b1;   // Latched while the timer interrupt was high.

        repeat (6) begin
            value = $random(seed);
            write_reg(ENABLE_ADDR, value, 1'b0);
            model_enable = value[IRQ_NUM-1:0];
            value     = $random(seed);
            ext_src_i = value[3:0];
            @(negedge clk);
            ext_src_i     = '0;
            model_pending = model_pending | {value[3:0], 1'b0};
            read_reg(PENDING_ADDR, DATA_W'(model_pending), '1, 1'b0, rdata);
            check_bit(ext_irq_o, |(model_pending & model_enable), "ext_irq_o before claims");
            claim  = 1;
            cycles = 0;
            while (claim != 0 && cycles <= IRQ_NUM) begin
                claim = expected_claim(model_pending, model_enable);
                read_reg(CLAIM_ADDR, claim, '1, 1'b0, rdata);
                if (claim != 0)
                    model_pending = model_pending & ~(IRQ_NUM'(1) << (claim - 1));
                cycles++;
            end
            check_bit(ext_irq_o, 1'b0, "ext_irq_o after all claims");
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end
endmodule

// File: source/periph_soc.sv
`timescale 1ns/1ps

module periph_soc import soc_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,

    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              resp_valid_o,
    output logic [DATA_W-1:0] resp_rdata_o,
    output logic              resp_err_o,

    input  logic [3:0]        ext_src_i,
    output logic              ext_irq_o,
    output logic              timer_irq_o
);
    apb_if timer_apb();
    apb_if irqc_apb();

    logic               timer_irq;
    logic [IRQ_NUM-1:0] irq_src;

    assign irq_src     = {ext_src_i, timer_irq};   // Timer is source 0.
    assign timer_irq_o = timer_irq;

    apb_bridge u_apb_bridge (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_err_o   (resp_err_o),
        .resp_rdata_o (resp_rdata_o),
        .timer_apb    (timer_apb.master),
        .irqc_apb     (irqc_apb.master)
    );

    clint_timer u_clint_timer (
        .clk         (clk),
        .reset_i     (reset_i),
        .apb         (timer_apb.slave),
        .timer_irq_o (timer_irq)
    );

    irq_ctrl u_irq_ctrl (
        .clk       (clk),
        .reset_i   (reset_i),
        .apb       (irqc_apb.slave),
        .src_i     (irq_src),
        .ext_irq_o (ext_irq_o)
    );
endmodule

// File: source/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl import soc_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    apb_if.slave               apb,
    input  logic [IRQ_NUM-1:0] src_i,
    output logic               ext_irq_o
);
    logic [IRQ_NUM-1:0] pending_q;
    logic [IRQ_NUM-1:0] enable_q;
    logic [IRQ_NUM-1:0] active;
    logic [IRQ_NUM-1:0] claim_mask;
    logic [IRQ_NUM-1:0] clr_mask;
    logic [DATA_W-1:0]  claim_id;
    logic               irq_q;
    logic [OFF_W-1:0]   off;
    logic               off_ok;
    logic               acc;

    assign off    = apb.paddr[OFF_W-1:0];
    assign acc    = apb.psel & apb.penable & off_ok;
    assign active = pending_q & enable_q;

    // Lowest active source wins, id is index plus one.
    always_comb begin
        claim_id   = '0;
        claim_mask = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id      = DATA_W'(i + 1);
                claim_mask    = '0;
                claim_mask[i] = 1'b1;
            end
        end
    end

    always_comb begin
        off_ok     = 1'b0;
        apb.prdata = '0;
        if (apb.paddr[ADDR_W-1:OFF_W] == '0) begin
            case (off)
                OFF_PENDING: begin
                    off_ok     = ~apb.pwrite;   // Pending is read only.
                    apb.prdata = DATA_W'(pending_q);
                end
                OFF_ENABLE: begin
                    off_ok     = 1'b1;
                    apb.prdata = DATA_W'(enable_q);
                end
                OFF_CLAIM: begin
                    off_ok     = 1'b1;
                    apb.prdata = claim_id;
                end
                default: off_ok = 1'b0;
            endcase
        end
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = apb.psel & ~off_ok;
    assign clr_mask    = (acc && !apb.pwrite && off == OFF_CLAIM) ? claim_mask : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q <= '0;
            enable_q  <= '0;
            irq_q     <= 1'b0;
        end else begin
            // Claim clears win, a level source sets the bit again next cycle.
            pending_q <= (pending_q | src_i) & ~clr_mask;
            if (acc && apb.pwrite && off == OFF_ENABLE)
                enable_q <= apb.pwdata[IRQ_NUM-1:0];
            irq_q <= |active;
        end
    end

    assign ext_irq_o = irq_q;
endmodule

// File: source/clint_timer.sv
`timescale 1ns/1ps

module clint_timer import soc_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    apb_if.slave  apb,
    output logic  timer_irq_o
);
    logic [DATA_W-1:0] mtime_q;
    logic [DATA_W-1:0] mtimecmp_q;
    logic              enable_q;
    logic              irq_q;
    logic [OFF_W-1:0]  off;
    logic              off_ok;
    logic              wr_en;

    assign off   = apb.paddr[OFF_W-1:0];
    assign wr_en = apb.psel & apb.penable & apb.pwrite & off_ok;

    // Read mux and offset check.
    always_comb begin
        off_ok     = 1'b0;
        apb.prdata = '0;
        if (apb.paddr[ADDR_W-1:OFF_W] == '0) begin
            case (off)
                OFF_MTIME: begin
                    off_ok     = 1'b1;
                    apb.prdata = mtime_q;
                end
                OFF_MTIMECMP: begin
                    off_ok     = 1'b1;
                    apb.prdata = mtimecmp_q;
                end
                OFF_CTRL: begin
                    off_ok                  = 1'b1;
                    apb.prdata[CTRL_EN_BIT] = enable_q;
                end
                default: off_ok = 1'b0;
            endcase
        end
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = apb.psel & ~off_ok;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '0;
            enable_q   <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            if (wr_en && off == OFF_MTIME)
                mtime_q <= apb.pwdata;   // A write wins over the count.
            else if (enable_q)
                mtime_q <= mtime_q + 1'b1;
            if (wr_en && off == OFF_MTIMECMP)
                mtimecmp_q <= apb.pwdata;
            if (wr_en && off == OFF_CTRL)
                enable_q <= apb.pwdata[CTRL_EN_BIT];   // Reserved bits dropped.
            irq_q <= enable_q && (mtime_q >= mtimecmp_q);
        end
    end

    assign timer_irq_o = irq_q;
endmodule

// File: source/apb_bridge.sv
`timescale 1ns/1ps

module apb_bridge import soc_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,

    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,

    output logic              resp_valid_o,
    output logic              resp_err_o,
    output logic [DATA_W-1:0] resp_rdata_o,

    apb_if.master             timer_apb,
    apb_if.master             irqc_apb
);
    bridge_state_e     state_q;
    apb_target_e       tgt_q;
    apb_target_e       tgt_dec;
    logic              write_q;
    logic [OFF_W-1:0]  off_q;
    logic [DATA_W-1:0] wdata_q;
    logic              resp_valid_q;
    logic              resp_err_q;
    logic [DATA_W-1:0] resp_rdata_q;
    logic              in_xfer;
    logic              done;
    logic              slv_ready;
    logic              slv_err;
    logic [DATA_W-1:0] slv_rdata;

    // Region decode on the upper address bits.
    always_comb begin
        if (req_addr_i[ADDR_W-1:OFF_W] == TIMER_BASE[ADDR_W-1:OFF_W])
            tgt_dec = TGT_TIMER;
        else if (req_addr_i[ADDR_W-1:OFF_W] == IRQC_BASE[ADDR_W-1:OFF_W])
            tgt_dec = TGT_IRQC;
        else
            tgt_dec = TGT_NONE;
    end

    always_comb begin
        case (tgt_q)
            TGT_TIMER: begin
                slv_ready = timer_apb.pready;
                slv_err   = timer_apb.pslverr;
                slv_rdata = timer_apb.prdata;
            end
            TGT_IRQC: begin
                slv_ready = irqc_apb.pready;
                slv_err   = irqc_apb.pslverr;
                slv_rdata = irqc_apb.prdata;
            end
            default: begin   // Unmapped, completes at once with an error.
                slv_ready = 1'b1;
                slv_err   = 1'b1;
                slv_rdata = '0;
            end
        endcase
    end

    assign in_xfer = (state_q == SETUP) || (state_q == ACCESS);
    assign done    = (state_q == ACCESS) && slv_ready;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            tgt_q        <= TGT_NONE;
            resp_valid_q <= 1'b0;
            resp_err_q   <= 1'b0;
        end else begin
            resp_valid_q <= done;
            resp_err_q   <= done & slv_err;
            case (state_q)
                IDLE: if (req_valid_i) begin   // Strobes in other states are dropped.
                    state_q <= SETUP;
                    tgt_q   <= tgt_dec;
                end
                SETUP:   state_q <= ACCESS;
                ACCESS:  if (slv_ready) state_q <= RESP;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid_i) begin
            write_q <= req_write_i;
            off_q   <= req_addr_i[OFF_W-1:0];
            wdata_q <= req_wdata_i;
        end
        if (done)
            resp_rdata_q <= slv_rdata;
    end

    assign timer_apb.psel    = in_xfer && (tgt_q == TGT_TIMER);
    assign timer_apb.penable = (state_q == ACCESS) && (tgt_q == TGT_TIMER);
    assign timer_apb.pwrite  = write_q;
    assign timer_apb.paddr   = {{(ADDR_W-OFF_W){1'b0}}, off_q};
    assign timer_apb.pwdata  = wdata_q;

    assign irqc_apb.psel     = in_xfer && (tgt_q == TGT_IRQC);
    assign irqc_apb.penable  = (state_q == ACCESS) && (tgt_q == TGT_IRQC);
    assign irqc_apb.pwrite   = write_q;
    assign irqc_apb.paddr    = {{(ADDR_W-OFF_W){1'b0}}, off_q};
    assign irqc_apb.pwdata   = wdata_q;

    assign resp_valid_o = resp_valid_q;
    assign resp_err_o   = resp_err_q;
    assign resp_rdata_o = resp_rdata_q;
endmodule

// File: source/apb_if.sv
`timescale 1ns/1ps

interface apb_if import soc_pkg::*; ();
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;   // Offset within the region only.
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );
endinterface

// File: source/soc_pkg.sv
package soc_pkg;

    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int IRQ_NUM = 5;   // Source 0 is the timer, 1 to 4 are external.
    localparam int OFF_W   = 8;   // Each region spans 256 bytes.

    // Region bases, anything else is unmapped.
    localparam logic [ADDR_W-1:0] TIMER_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] IRQC_BASE  = 16'h0100;

    localparam int CTRL_EN_BIT = 0;

    // Timer register offsets.
    typedef enum logic [OFF_W-1:0] {
        OFF_MTIME    = 8'h00,
        OFF_MTIMECMP = 8'h04,
        OFF_CTRL     = 8'h08
    } timer_off_e;

    // Interrupt controller register offsets.
    typedef enum logic [OFF_W-1:0] {
        OFF_PENDING = 8'h00,   // Read only.
        OFF_ENABLE  = 8'h04,
        OFF_CLAIM   = 8'h08
    } irqc_off_e;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP
    } bridge_state_e;

    typedef enum logic [1:0] {
        TGT_TIMER,
        TGT_IRQC,
        TGT_NONE
    } apb_target_e;

endpackage
